/* vmul_top.f */
+incdir+verilog
verilog/vmul_pkg.sv
verilog/vmul_twos_comp_sel.sv
verilog/vmul_vedic_core.sv
verilog/vmul_datapath.sv
verilog/vmul_ctrl.sv
verilog/vmul_top.sv
verif/vmul_tb_clk.sv
verif/vmul_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vmul testbench with Verilator, result judged from sim.log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vmul_tb -f vmul_top.f \
    -o vmul_sim > build.log 2>&1 && ./obj_dir/vmul_sim > sim.log 2>&1
[ -f sim.log ] && cat sim.log || { echo "Build failed, see build.log"; exit 1; }
grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

/* verif/vmul_tb.sv */
// Vector multiply testbench
// Directed and LFSR-random transactions through the four-phase handshake
// with results compared against a per-element reference model

`timescale 1ns/100ps
`include "vmul_config.svh"

module vmul_tb;

    localparam int DW           = `VMUL_DATA_WIDTH;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_DIRECTED = 28;
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_HOLD     = 7;
    // Drive, accept, latency, hold, release and ack fall
    localparam int TXN_CYCLES      = `VMUL_LATENCY + MAX_HOLD + 6;
    localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * TXN_CYCLES
                                     + RESET_CYCLES + 50;

    logic                  clk;
    logic                  rst;
    logic                  req;
    vmul_pkg::vmul_op_t    op;
    vmul_pkg::vmul_osize_t osize;
    logic [DW-1:0]         srca;
    logic [DW-1:0]         srcb;
    logic                  ack;
    logic [DW-1:0]         result;

    logic [31:0]   lfsr_state;
    logic [DW-1:0] exp_q[$];
    string         desc_q[$];
    logic          ack_q;
    logic [DW-1:0] held_result;

    vmul_tb_clk #(
        .CLK_PERIOD   (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk (
        .clk (clk),
        .rst (rst)
    );

    vmul_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .osize  (osize),
        .srca   (srca),
        .srcb   (srcb),
        .ack    (ack),
        .result (result)
    );

    task automatic check(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s (got %h, expected %h)", $time, what, actual,
                     expected);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [DW-1:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[DW-2:0], lfsr_state[0]};
        end
    endtask

    // Same element value in every lane of the word
    function automatic logic [DW-1:0] fill_elements(input vmul_pkg::vmul_osize_t f_osize,
                                                    input logic [DW-1:0] elem);
        int            ew;
        logic [DW-1:0] mask;
        logic [DW-1:0] word;

        ew   = `VMUL_BYTE_WIDTH << int'(f_osize);
        mask = (DW'(1) << ew) - 1;
        word = '0;
        for (int e = 0; e < DW / ew; e++) begin
            word = word | ((elem & mask) << (e * ew));
        end
        return word;
    endfunction

    // Expected word from each element widened to 128 bits and multiplied
    function automatic logic [DW-1:0] ref_result(input vmul_pkg::vmul_op_t f_op,
                                                 input vmul_pkg::vmul_osize_t f_osize,
                                                 input logic [DW-1:0] a,
                                                 input logic [DW-1:0] b);
        int              ew;
        logic [2*DW-1:0] mask;
        logic [2*DW-1:0] ea;
        logic [2*DW-1:0] eb;
        logic [2*DW-1:0] prod;
        logic [DW-1:0]   res;

        ew   = `VMUL_BYTE_WIDTH << int'(f_osize);
        mask = ((2*DW)'(1) << ew) - 1;
        res  = '0;
        for (int e = 0; e < DW / ew; e++) begin
            ea = ((2*DW)'(a) >> (e * ew)) & mask;
            eb = ((2*DW)'(b) >> (e * ew)) & mask;
            // Sign extension only for vmulh
            if (f_op == vmul_pkg::VMUL_OP_MULH) begin
                if (ea[ew-1]) begin
                    ea = ea | ~mask;
                end
                if (eb[ew-1]) begin
                    eb = eb | ~mask;
                end
            end
            prod = ea * eb;
            if (f_op != vmul_pkg::VMUL_OP_MUL) begin
                prod = prod >> ew;
            end
            res = res | DW'((prod & mask) << (e * ew));
        end
        return res;
    endfunction

    task automatic run_txn(input vmul_pkg::vmul_op_t t_op, input vmul_pkg::vmul_osize_t t_osize,
                           input logic [DW-1:0] a, input logic [DW-1:0] b, input int hold);
        int waited;

        exp_q.push_back(ref_result(t_op, t_osize, a, b));
        desc_q.push_back($sformatf("result of %s osize %0d a %h b %h", t_op.name(),
                                   int'(t_osize), a, b));
        @(posedge clk);
        req   <= 1'b1;
        op    <= t_op;
        osize <= t_osize;
        srca  <= a;
        srcb  <= b;
        // Next edge is the accepting one
        @(posedge clk);
        waited = 0;
        @(negedge clk);
        while (!ack && waited <= `VMUL_LATENCY + 2) begin
            @(negedge clk);
            waited++;
        end
        check(DW'(waited), DW'(`VMUL_LATENCY), "ack latency in cycles after accept");
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check(DW'(ack), DW'(1), "ack dropped before req was sampled low");
        @(negedge clk);
        check(DW'(ack), DW'(0), "ack still high one edge after req was sampled low");
    endtask

    // Compare on every rising ack and watch result while ack stays up
    always @(negedge clk) begin
        if (rst) begin
            ack_q = 1'b0;
        end else begin
            if (ack && !ack_q) begin
                check(DW'(exp_q.size()), DW'(1), "ack without an outstanding request");
                check(result, exp_q.pop_front(), desc_q.pop_front());
                held_result = result;
            end else if (ack) begin
                check(result, held_result, "result changed while ack held");
            end
            ack_q = ack;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the handshake hung", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        logic [DW-1:0]         ra;
        logic [DW-1:0]         rb;
        logic [DW-1:0]         rbits;
        logic [DW-1:0]         mn;
        logic [DW-1:0]         mx;
        vmul_pkg::vmul_op_t    r_op;
        vmul_pkg::vmul_osize_t sz;
        int                    ew;

        lfsr_state  = 32'h5e57;
        req   <= 1'b0;
        op    <= vmul_pkg::VMUL_OP_MUL;
        osize <= vmul_pkg::OSIZE_8;
        srca  <= '0;
        srcb  <= '0;

        @(negedge rst);
        // Idle after reset
        repeat (5) begin
            @(negedge clk);
            check(DW'(ack), DW'(0), "ack high after reset with req low");
        end

        // Low halves of products that wrap
        for (int s = 0; s < `VMUL_NUM_OSIZES; s++) begin
            sz = vmul_pkg::vmul_osize_t'(s);
            run_txn(vmul_pkg::VMUL_OP_MUL, sz, '1, 64'h0123456789abcdef, s);
            run_txn(vmul_pkg::VMUL_OP_MUL, sz, 64'hfedcba9876543210, 64'h0f1e2d3c4b5a6978, 0);
        end

        // Signed high halves around the most negative element
        for (int s = 0; s < `VMUL_NUM_OSIZES; s++) begin
            sz = vmul_pkg::vmul_osize_t'(s);
            ew = `VMUL_BYTE_WIDTH << s;
            mn = fill_elements(sz, DW'(1) << (ew - 1));
            mx = fill_elements(sz, (DW'(1) << (ew - 1)) - 1);
            run_txn(vmul_pkg::VMUL_OP_MULH, sz, mn, mn, s);
            run_txn(vmul_pkg::VMUL_OP_MULH, sz, mn, '1, 0);
            run_txn(vmul_pkg::VMUL_OP_MULH, sz, mn, mx, 1);
        end

        // Unsigned high halves of all-ones elements
        for (int s = 0; s < `VMUL_NUM_OSIZES; s++) begin
            sz = vmul_pkg::vmul_osize_t'(s);
            run_txn(vmul_pkg::VMUL_OP_MULHU, sz, '1, '1, s);
            run_txn(vmul_pkg::VMUL_OP_MULHU, sz, '1, 64'h8040201008040201, 0);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            take_bits(8, rbits);
            r_op = vmul_pkg::vmul_op_t'(2'(rbits % 3));
            take_bits(2, rbits);
            sz = vmul_pkg::vmul_osize_t'(rbits[1:0]);
            take_bits(DW, ra);
            take_bits(DW, rb);
            take_bits(3, rbits);
            run_txn(r_op, sz, ra, rb, int'(rbits[2:0]));
        end

        repeat (2) @(posedge clk);

        $display("** PASS **");
        $finish;
    end

endmodule

/* verif/vmul_tb_clk.sv */
// Testbench clock and reset
// Free-running clock, reset held high for a fixed number of cycles

`timescale 1ns/100ps

module vmul_tb_clk #(
    parameter int CLK_PERIOD   = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD/2) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* verilog/vmul_top.sv */
// Vector multiply unit
// Handshake controller driving the three-stage multiply datapath

`timescale 1ns/100ps
`include "vmul_config.svh"

module vmul_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,
    input  vmul_pkg::vmul_op_t          op,
    input  vmul_pkg::vmul_osize_t       osize,
    input  logic [`VMUL_DATA_WIDTH-1:0] srca,
    input  logic [`VMUL_DATA_WIDTH-1:0] srcb,
    output logic                        ack,
    output logic [`VMUL_DATA_WIDTH-1:0] result
);

    // Stage enables
    logic load_operands;
    logic load_product;
    logic load_result;

    vmul_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .ack           (ack),
        .load_operands (load_operands),
        .load_product  (load_product),
        .load_result   (load_result)
    );

    vmul_datapath u_datapath (
        .clk           (clk),
        .rst           (rst),
        .load_operands (load_operands),
        .load_product  (load_product),
        .load_result   (load_result),
        .op            (op),
        .osize         (osize),
        .srca          (srca),
        .srcb          (srcb),
        .result        (result)
    );

endmodule

/* verilog/vmul_ctrl.sv */
// Vector multiply controller
// Four-phase req/ack handshake, one load pulse per datapath stage

`timescale 1ns/100ps

module vmul_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req,
    output logic ack,
    output logic load_operands,
    output logic load_product,
    output logic load_result
);

    vmul_pkg::vmul_state_t state;
    vmul_pkg::vmul_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            vmul_pkg::ST_IDLE: begin
                if (req) begin
                    state_next = vmul_pkg::ST_MUL;
                end
            end
            vmul_pkg::ST_MUL: begin
                state_next = vmul_pkg::ST_RESULT;
            end
            vmul_pkg::ST_RESULT: begin
                state_next = vmul_pkg::ST_ACK;
            end
            vmul_pkg::ST_ACK: begin
                // Wait for the requester to let go
                if (!req) begin
                    state_next = vmul_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = vmul_pkg::ST_IDLE;
            end
        endcase
    end

    // Enables are pulsed on the transition out of each state
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= vmul_pkg::ST_IDLE;
            ack           <= 1'b0;
            load_operands <= 1'b0;
            load_product  <= 1'b0;
            load_result   <= 1'b0;
        end else begin
            state         <= state_next;
            load_operands <= (state == vmul_pkg::ST_IDLE) && req;
            load_product  <= (state == vmul_pkg::ST_MUL);
            load_result   <= (state == vmul_pkg::ST_RESULT);
            // result lands together with ack, held while req stays up
            ack           <= (state == vmul_pkg::ST_ACK) && req;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack) |-> req
    ) else $error("ack raised with req low");

    a_one_load: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({load_operands, load_product, load_result})
    ) else $error("more than one load enable active");

endmodule

/* verilog/vmul_datapath.sv */
// Vector multiply datapath
// Magnitudes into the vedic core, per-element sign fix on the product,
// low or high half select, three register stages

`timescale 1ns/100ps
`include "vmul_config.svh"

module vmul_datapath (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_operands,
    input  logic                        load_product,
    input  logic                        load_result,
    input  vmul_pkg::vmul_op_t          op,
    input  vmul_pkg::vmul_osize_t       osize,
    input  logic [`VMUL_DATA_WIDTH-1:0] srca,
    input  logic [`VMUL_DATA_WIDTH-1:0] srcb,
    output logic [`VMUL_DATA_WIDTH-1:0] result
);

    localparam int DW = `VMUL_DATA_WIDTH;
    localparam int BW = `VMUL_BYTE_WIDTH;
    localparam int NB = `VMUL_NUM_BYTES;
    localparam int PW = 2*DW;

    logic [NB-1:0] sign_a;
    logic [NB-1:0] sign_b;
    logic [NB-1:0] comp_a;
    logic [NB-1:0] comp_b;
    logic [NB-1:0] comp_res;
    logic [DW-1:0] mag_a;
    logic [DW-1:0] mag_b;

    vmul_pkg::vmul_op_t    op_q;
    vmul_pkg::vmul_osize_t osize_q;
    logic [DW-1:0]         mag_a_q;
    logic [DW-1:0]         mag_b_q;
    logic [NB-1:0]         comp_res_q;

    logic [PW-1:0] prod8;
    logic [PW-1:0] prod16;
    logic [PW-1:0] prod32;
    logic [PW-1:0] prod64;
    logic [PW-1:0] prod_sel;
    logic [PW-1:0] prod_q;
    logic [PW-1:0] prod_fix;
    logic [DW-1:0] half_sel;
    logic          take_high;

    // Element sign bits, parked on each element's lowest byte
    always_comb begin
        int seg;

        seg    = 1 << int'(osize);
        sign_a = '0;
        sign_b = '0;
        for (int blk = 0; blk < NB; blk++) begin
            if ((blk & (seg - 1)) == 0) begin
                sign_a[blk] = srca[(blk + seg)*BW - 1];
                sign_b[blk] = srcb[(blk + seg)*BW - 1];
            end
        end
    end

    // Only vmulh treats elements as signed
    assign comp_a   = sign_a & {NB{op == vmul_pkg::VMUL_OP_MULH}};
    assign comp_b   = sign_b & {NB{op == vmul_pkg::VMUL_OP_MULH}};
    assign comp_res = comp_a ^ comp_b;

    vmul_twos_comp_sel #(.BLOCK_WIDTH(BW)) u_comp_a (
        .in         (srca),
        .complement (comp_a),
        .osize      (osize),
        .out        (mag_a)
    );

    vmul_twos_comp_sel #(.BLOCK_WIDTH(BW)) u_comp_b (
        .in         (srcb),
        .complement (comp_b),
        .osize      (osize),
        .out        (mag_b)
    );

    // Stage 1, operands and controls
    always_ff @(posedge clk) begin
        if (load_operands) begin
            op_q       <= op;
            osize_q    <= osize;
            mag_a_q    <= mag_a;
            mag_b_q    <= mag_b;
            comp_res_q <= comp_res;
        end
    end

    vmul_vedic_core u_vedic (
        .a      (mag_a_q),
        .b      (mag_b_q),
        .prod8  (prod8),
        .prod16 (prod16),
        .prod32 (prod32),
        .prod64 (prod64)
    );

    always_comb begin
        case (osize_q)
            vmul_pkg::OSIZE_8:  prod_sel = prod8;
            vmul_pkg::OSIZE_16: prod_sel = prod16;
            vmul_pkg::OSIZE_32: prod_sel = prod32;
            default:            prod_sel = prod64;
        endcase
    end

    // Stage 2, unsigned element products
    always_ff @(posedge clk) begin
        if (load_product) begin
            prod_q <= prod_sel;
        end
    end

    // Restore sign on double-width lanes
    vmul_twos_comp_sel #(.BLOCK_WIDTH(2*BW)) u_comp_res (
        .in         (prod_q),
        .complement (comp_res_q),
        .osize      (osize_q),
        .out        (prod_fix)
    );

    assign take_high = (op_q != vmul_pkg::VMUL_OP_MUL);

    // Pick low or high half of every lane, byte by byte
    always_comb begin
        int shift;
        int base;

        shift = int'(osize_q);
        for (int blk = 0; blk < NB; blk++) begin
            // lane start in bytes plus byte offset inside the element
            base = ((blk >> shift) << (shift + 1)) + (blk & ((1 << shift) - 1));
            if (take_high) begin
                base = base + (1 << shift);
            end
            half_sel[blk*BW +: BW] = prod_fix[base*BW +: BW];
        end
    end

    // Stage 3, final result
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (load_result) begin
            result <= half_sel;
        end
    end

    // Product stage only ever directly after the operand stage
    a_product_after_operands: assert property (
        @(posedge clk) disable iff (rst) load_product |-> $past(load_operands)
    ) else $error("load_product not preceded by load_operands");

endmodule

/* verilog/vmul_vedic_core.sv */
// Unsigned vedic multiplier, 64x64
// Built from 8x8 leaf products joined level by level; the diagonal
// blocks of each level are the per-element products of that size

`timescale 1ns/100ps
`include "vmul_config.svh"

module vmul_vedic_core (
    input  logic [`VMUL_DATA_WIDTH-1:0]   a,
    input  logic [`VMUL_DATA_WIDTH-1:0]   b,
    output logic [2*`VMUL_DATA_WIDTH-1:0] prod8,
    output logic [2*`VMUL_DATA_WIDTH-1:0] prod16,
    output logic [2*`VMUL_DATA_WIDTH-1:0] prod32,
    output logic [2*`VMUL_DATA_WIDTH-1:0] prod64
);

    localparam int BW = `VMUL_BYTE_WIDTH;
    localparam int NB = `VMUL_NUM_BYTES;
    localparam int PW = 2*`VMUL_DATA_WIDTH;

    // Block products, first index is the A block, second the B block
    logic [2*BW-1:0] pp8  [NB][NB];
    logic [4*BW-1:0] pp16 [NB/2][NB/2];
    logic [8*BW-1:0] pp32 [NB/4][NB/4];

    // Join four half-width products into one of double width
    function automatic logic [PW-1:0] vedic_join(
        input logic [PW-1:0] ll,
        input logic [PW-1:0] lh,
        input logic [PW-1:0] hl,
        input logic [PW-1:0] hh,
        input int            hw
    );
        return ll + ((lh + hl) << hw) + (hh << (2*hw));
    endfunction

    // Leaf 8x8 products
    for (genvar i = 0; i < NB; i++) begin : gen_lvl8_a
        for (genvar j = 0; j < NB; j++) begin : gen_lvl8_b
            assign pp8[i][j] = a[i*BW +: BW] * b[j*BW +: BW];
        end
    end

    // 16x16 from four 8x8
    for (genvar i = 0; i < NB/2; i++) begin : gen_lvl16_a
        for (genvar j = 0; j < NB/2; j++) begin : gen_lvl16_b
            assign pp16[i][j] = (4*BW)'(vedic_join(PW'(pp8[2*i][2*j]),
                                                   PW'(pp8[2*i][2*j+1]),
                                                   PW'(pp8[2*i+1][2*j]),
                                                   PW'(pp8[2*i+1][2*j+1]),
                                                   BW));
        end
    end

    // 32x32 from four 16x16
    for (genvar i = 0; i < NB/4; i++) begin : gen_lvl32_a
        for (genvar j = 0; j < NB/4; j++) begin : gen_lvl32_b
            assign pp32[i][j] = (8*BW)'(vedic_join(PW'(pp16[2*i][2*j]),
                                                   PW'(pp16[2*i][2*j+1]),
                                                   PW'(pp16[2*i+1][2*j]),
                                                   PW'(pp16[2*i+1][2*j+1]),
                                                   2*BW));
        end
    end

    // Full product
    assign prod64 = vedic_join(PW'(pp32[0][0]), PW'(pp32[0][1]),
                               PW'(pp32[1][0]), PW'(pp32[1][1]), 4*BW);

    // Diagonal blocks packed as double-width lanes
    for (genvar k = 0; k < NB; k++) begin : gen_diag8
        assign prod8[k*2*BW +: 2*BW] = pp8[k][k];
    end

    for (genvar k = 0; k < NB/2; k++) begin : gen_diag16
        assign prod16[k*4*BW +: 4*BW] = pp16[k][k];
    end

    for (genvar k = 0; k < NB/4; k++) begin : gen_diag32
        assign prod32[k*8*BW +: 8*BW] = pp32[k][k];
    end

endmodule

/* verilog/vmul_twos_comp_sel.sv */
// Segmented two's complement
// Blocks are grouped into element-sized segments; a segment is negated
// when the flag on its lowest block is set, otherwise passed through

`timescale 1ns/100ps
`include "vmul_config.svh"

module vmul_twos_comp_sel #(
    parameter int BLOCK_WIDTH = 8
) (
    input  logic [`VMUL_NUM_BYTES-1:0][BLOCK_WIDTH-1:0] in,
    input  logic [`VMUL_NUM_BYTES-1:0]                  complement,
    input  vmul_pkg::vmul_osize_t                       osize,
    output logic [`VMUL_NUM_BYTES-1:0][BLOCK_WIDTH-1:0] out
);

    localparam int NUM_BLOCKS = `VMUL_NUM_BYTES;

    always_comb begin
        logic [BLOCK_WIDTH:0] sum;
        logic                 carry;
        int                   seg_mask;
        int                   seg_lsb;

        // Blocks per segment minus one
        seg_mask = (1 << int'(osize)) - 1;
        carry    = 1'b0;

        for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
            seg_lsb = blk & ~seg_mask;

            // Invert and add one, the +1 enters at the bottom of each segment
            if (blk == seg_lsb) begin
                carry = 1'b1;
            end
            sum   = {1'b0, ~in[blk]} + {{BLOCK_WIDTH{1'b0}}, carry};
            carry = sum[BLOCK_WIDTH];

            // Whole segment follows the flag of its lowest block
            if (complement[seg_lsb]) begin
                out[blk] = sum[BLOCK_WIDTH-1:0];
            end else begin
                out[blk] = in[blk];
            end
        end
    end

endmodule

/* verilog/vmul_pkg.sv */
// Vector multiply types
// Operation, element size and controller state encodings

package vmul_pkg;

    // Multiply flavours
    typedef enum logic [1:0] {
        VMUL_OP_MUL   = 2'b00,
        VMUL_OP_MULH  = 2'b01,
        VMUL_OP_MULHU = 2'b10
    } vmul_op_t;

    // Encoding is log2 of the element size in bytes
    typedef enum logic [1:0] {
        OSIZE_8  = 2'd0,
        OSIZE_16 = 2'd1,
        OSIZE_32 = 2'd2,
        OSIZE_64 = 2'd3
    } vmul_osize_t;

    // Handshake controller states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_MUL    = 2'd1,
        ST_RESULT = 2'd2,
        ST_ACK    = 2'd3
    } vmul_state_t;

endpackage

/* verilog/vmul_config.svh */
// Vector multiply configuration
// Word, element and latency constants shared by RTL and testbench

`ifndef VMUL_CONFIG_SVH
`define VMUL_CONFIG_SVH

// Data word and smallest element
`define VMUL_DATA_WIDTH 64
`define VMUL_BYTE_WIDTH 8
`define VMUL_NUM_BYTES  (`VMUL_DATA_WIDTH/`VMUL_BYTE_WIDTH)

// Element sizes 8, 16, 32 and 64 bits
`define VMUL_NUM_OSIZES 4

// Cycles from the accepting edge to ack
`define VMUL_LATENCY 3

`endif
